// File: dv/mem_subsystem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_tb;

    import mem_arb_pkg::*;

    localparam int ADDR_WIDTH      = 6;
    localparam int LINE_WIDTH      = 64;
    localparam int MEM_LATENCY     = 3;
    localparam int DEPTH           = 1 << ADDR_WIDTH;
    localparam int RESET_CYCLES    = 4;
    localparam int RANDOM_PER_PORT = 100;
    localparam int DIRECTED_TXN    = 10;
    localparam int MAX_GAP         = 3;
    localparam int TOTAL_TXN       = DIRECTED_TXN + 2 * RANDOM_PER_PORT;
    localparam int TIMEOUT_CYCLES  =
        RESET_CYCLES + TOTAL_TXN * (MEM_LATENCY + 2 + MAX_GAP) + 100;

    typedef logic [LINE_WIDTH-1:0] line_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] i_addr;
    logic                  i_read;
    line_t                 i_rdata;
    logic                  i_resp;
    logic [ADDR_WIDTH-1:0] d_addr;
    logic                  d_read;
    logic                  d_write;
    line_t                 d_wdata;
    line_t                 d_rdata;
    logic                  d_resp;

    logic [15:0] lfsr;
    line_t       model [DEPTH];
    int          i_stamp;
    int          d_stamp;

    mem_subsystem
    #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .LINE_WIDTH  (LINE_WIDTH),
        .MEM_LATENCY (MEM_LATENCY)
    )
    dut
    (
        .clk     (clk),
        .rst     (rst),
        .i_addr  (i_addr),
        .i_read  (i_read),
        .i_rdata (i_rdata),
        .i_resp  (i_resp),
        .d_addr  (d_addr),
        .d_read  (d_read),
        .d_write (d_write),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_resp  (d_resp)
    );

    always #10 clk = ~clk;

    // ============================================================
    // helpers
    // ============================================================

    // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit.
    function automatic line_t random_bits(input int count);
        line_t value;
        logic  feedback;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr     = {lfsr[14:0], feedback};
            value    = {value[LINE_WIDTH-2:0], feedback};
        end
        return value;
    endfunction

    task automatic check_value(input line_t expected, input line_t actual, input string what);
        if (expected !== actual)
        begin
            $display("Fail at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // called one falling edge after i_read went up.
    task automatic wait_instruction_resp();
        while (!i_resp)
        begin
            @(negedge clk);
        end
        check_value(model[i_addr], i_rdata, "i_rdata");
        @(negedge clk);
        check_value('0, line_t'(i_resp), "i_resp longer than one cycle");
        i_read = 1'b0;
    endtask

    task automatic instruction_read(input logic [ADDR_WIDTH-1:0] addr);
        i_addr = addr;
        i_read = 1'b1;
        @(negedge clk);
        wait_instruction_resp();
    endtask

    // hold keeps the strobes up so the next call chains onto the grant.
    task automatic data_access(input mem_op_t op, input logic [ADDR_WIDTH-1:0] addr,
                               input line_t data, input logic hold, input logic i_blocked);
        d_addr  = addr;
        d_read  = (op == OP_READ);
        d_write = (op == OP_WRITE);
        d_wdata = data;
        do
        begin
            @(negedge clk);
            if (i_blocked)
            begin
                check_value('0, line_t'(i_resp), "i_resp while the data port holds the grant");
            end
        end
        while (!d_resp);
        if (op == OP_READ)
        begin
            check_value(model[addr], d_rdata, "d_rdata");
        end
        else
        begin
            model[addr] = data;
        end
        @(negedge clk);
        check_value('0, line_t'(d_resp), "d_resp longer than one cycle");
        if (i_blocked)
        begin
            check_value('0, line_t'(i_resp), "i_resp before the data port let go");
        end
        if (!hold)
        begin
            d_read  = 1'b0;
            d_write = 1'b0;
        end
    endtask

    // both ports run side by side, one decision per falling edge.
    task automatic run_traffic(input int i_total, input int d_total);
        int      i_left;
        int      d_left;
        int      i_gap;
        int      d_gap;
        int      cycle;
        logic    i_ack;
        logic    d_ack;
        mem_op_t op;
        i_left = i_total;
        d_left = d_total;
        i_gap  = 0;
        d_gap  = 0;
        cycle  = 0;
        i_ack  = 1'b0;
        d_ack  = 1'b0;
        while (i_left > 0 || d_left > 0 || i_read || d_read || d_write)
        begin
            @(negedge clk);
            cycle++;
            if (i_read && !i_ack)
            begin
                if (i_resp)
                begin
                    check_value(model[i_addr], i_rdata, "i_rdata in traffic");
                    i_ack   = 1'b1;
                    i_stamp = cycle;
                end
            end
            else
            begin
                check_value('0, line_t'(i_resp), "i_resp with no request outstanding");
                i_ack = 1'b0;
                if (i_left > 0 && i_gap == 0)
                begin
                    i_addr = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
                    i_read = 1'b1;
                    i_gap  = int'(random_bits(2));
                    i_left--;
                end
                else
                begin
                    i_read = 1'b0;
                    i_gap  = (i_gap > 0) ? i_gap - 1 : 0;
                end
            end
            if ((d_read || d_write) && !d_ack)
            begin
                if (d_resp)
                begin
                    if (d_read)
                    begin
                        check_value(model[d_addr], d_rdata, "d_rdata in traffic");
                    end
                    else
                    begin
                        model[d_addr] = d_wdata;
                    end
                    d_ack   = 1'b1;
                    d_stamp = cycle;
                end
            end
            else
            begin
                check_value('0, line_t'(d_resp), "d_resp with no request outstanding");
                d_ack = 1'b0;
                if (d_left > 0 && d_gap == 0)
                begin
                    op      = random_bits(1) ? OP_WRITE : OP_READ;
                    d_addr  = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
                    d_wdata = random_bits(LINE_WIDTH);
                    d_read  = (op == OP_READ);
                    d_write = (op == OP_WRITE);
                    d_gap   = int'(random_bits(2));
                    d_left--;
                end
                else
                begin
                    d_read  = 1'b0;
                    d_write = 1'b0;
                    d_gap   = (d_gap > 0) ? d_gap - 1 : 0;
                end
            end
        end
    endtask

    // ============================================================
    // test sequence
    // ============================================================

    initial
    begin : main_sequence
        logic [ADDR_WIDTH-1:0] addr_a;
        logic [ADDR_WIDTH-1:0] addr_b;
        line_t                 data;
        lfsr    = 16'd88;
        rst     = 1'b1;
        i_addr  = '0;
        i_read  = 1'b0;
        d_addr  = '0;
        d_read  = 1'b0;
        d_write = 1'b0;
        d_wdata = '0;
        i_stamp = 0;
        d_stamp = 0;
        for (int i = 0; i < DEPTH; i++)
        begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // quiet after reset, memory reads back zero.
        @(negedge clk);
        check_value('0, line_t'(i_resp), "i_resp after reset");
        check_value('0, line_t'(d_resp), "d_resp after reset");
        instruction_read(ADDR_WIDTH'(random_bits(ADDR_WIDTH)));

        // data write, read back, then a line never written.
        addr_a = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
        addr_b = addr_a + 1'b1;
        data   = random_bits(LINE_WIDTH);
        data_access(OP_WRITE, addr_a, data, 1'b0, 1'b0);
        data_access(OP_READ, addr_a, '0, 1'b0, 1'b0);
        data_access(OP_READ, addr_b, '0, 1'b0, 1'b0);

        // shared memory seen from the instruction side.
        instruction_read(addr_a);

        // same-edge requests, instruction side first.
        run_traffic(1, 1);
        check_value(line_t'(1), line_t'(i_stamp < d_stamp), "i_resp not ahead of d_resp");

        // chained data requests starve a pending fetch.
        addr_a  = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
        data    = random_bits(LINE_WIDTH);
        d_addr  = addr_a;
        d_wdata = data;
        d_write = 1'b1;
        @(negedge clk);
        i_addr = addr_a;
        i_read = 1'b1;
        data_access(OP_WRITE, addr_a, data, 1'b1, 1'b1);
        data_access(OP_READ, addr_a, '0, 1'b0, 1'b1);
        wait_instruction_resp();

        run_traffic(RANDOM_PER_PORT, RANDOM_PER_PORT);

        $display("TEST OK");
        $finish;
    end

    initial
    begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Hang: no response from the memory subsystem within %0d cycles.",
                 TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule : mem_subsystem_tb

`default_nettype wire

// File: mem_arb.f
verilog/mem_arb_pkg.sv
verilog/mem_port_if.sv
verilog/arbiter_control.sv
verilog/cache_arbiter.sv
verilog/main_memory.sv
verilog/mem_subsystem.sv
dv/mem_subsystem_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f mem_arb.f --top-module mem_subsystem_tb

status=0
output=$(./obj_dir/Vmem_subsystem_tb 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed (exit status $status)"
exit 1

// File: verilog/arbiter_control.sv
`timescale 1ns/1ns
`default_nettype none

module arbiter_control
(
    input  logic clk,
    input  logic rst,
    input  logic icache_read,
    input  logic dcache_read,
    input  logic dcache_write,
    input  logic mem_resp,

    output logic mem_read,
    output logic mem_write,
    output logic icache_resp,
    output logic dcache_resp,
    output logic sel_dcache
);

    import mem_arb_pkg::*;

    arb_state_t state;
    arb_state_t next_state;

    // ============================================================
    // outputs from the current state
    // ============================================================

    always_comb
    begin : state_outputs
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        icache_resp = 1'b0;
        dcache_resp = 1'b0;
        sel_dcache  = 1'b0;

        unique case (state)
            ARB_IDLE:
            begin
                // no strobes while nobody is granted.
            end
            ARB_ICACHE:
            begin
                mem_read    = icache_read;
                icache_resp = mem_resp;
            end
            ARB_DCACHE:
            begin
                mem_read    = dcache_read;
                mem_write   = dcache_write;
                dcache_resp = mem_resp;
                sel_dcache  = 1'b1;
            end
            default:
            begin
            end
        endcase
    end

    // ============================================================
    // next state
    // ============================================================

    always_comb
    begin : next_state_logic
        next_state = state;

        unique case (state)
            ARB_IDLE:
            begin
                // instruction side has priority.
                if (icache_read)
                begin
                    next_state = ARB_ICACHE;
                end
                else if (dcache_read || dcache_write)
                begin
                    next_state = ARB_DCACHE;
                end
            end
            ARB_ICACHE:
            begin
                if (mem_resp)
                begin
                    next_state = ARB_IDLE;
                end
            end
            ARB_DCACHE:
            begin
                // keep the grant while a chained request is still up.
                if (!dcache_read && !dcache_write)
                begin
                    next_state = ARB_IDLE;
                end
            end
            default:
            begin
                next_state = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin : state_register
        if (rst)
        begin
            state <= ARB_IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

endmodule : arbiter_control

`default_nettype wire

// File: verilog/cache_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module cache_arbiter
#(
    parameter int ADDR_WIDTH = 6,
    parameter int LINE_WIDTH = 64
)
(
    input  logic       clk,
    input  logic       rst,
    mem_port_if.server icache,
    mem_port_if.server dcache,
    mem_port_if.client memory
);

    logic                  sel_dcache;
    logic                  icache_resp;
    logic                  dcache_resp;
    logic                  mem_read;
    logic                  mem_write;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [LINE_WIDTH-1:0] mem_wdata;

    arbiter_control control
    (
        .clk          (clk),
        .rst          (rst),
        .icache_read  (icache.read),
        .dcache_read  (dcache.read),
        .dcache_write (dcache.write),
        .mem_resp     (memory.resp),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .icache_resp  (icache_resp),
        .dcache_resp  (dcache_resp),
        .sel_dcache   (sel_dcache)
    );

    // ============================================================
    // request steering
    // ============================================================

    // instruction side never writes, so wdata comes from dcache only.
    always_comb
    begin : request_mux
        if (sel_dcache)
        begin
            mem_addr = dcache.addr;
        end
        else
        begin
            mem_addr = icache.addr;
        end
        mem_wdata = dcache.wdata;
    end

    assign memory.addr  = mem_addr;
    assign memory.wdata = mem_wdata;
    assign memory.read  = mem_read;
    assign memory.write = mem_write;

    // ============================================================
    // response fan-out
    // ============================================================

    // rdata goes to both, resp only to the granted port.
    assign icache.rdata = memory.rdata;
    assign dcache.rdata = memory.rdata;
    assign icache.resp  = icache_resp;
    assign dcache.resp  = dcache_resp;

endmodule : cache_arbiter

`default_nettype wire

// File: verilog/main_memory.sv
`timescale 1ns/1ns
`default_nettype none

module main_memory
#(
    parameter int ADDR_WIDTH  = 6,
    parameter int LINE_WIDTH  = 64,
    parameter int MEM_LATENCY = 3
)
(
    input  logic       clk,
    input  logic       rst,
    mem_port_if.server port
);

    import mem_arb_pkg::*;

    localparam int DEPTH     = 1 << ADDR_WIDTH;
    localparam int CNT_WIDTH = $clog2(MEM_LATENCY + 1);

    logic [LINE_WIDTH-1:0] lines [DEPTH];
    logic [CNT_WIDTH-1:0]  count;
    mem_op_t               op;
    logic                  resp;

    // ============================================================
    // strobe decode and latency counter
    // ============================================================

    always_comb
    begin : op_decode
        if (port.write)
        begin
            op = OP_WRITE;
        end
        else if (port.read)
        begin
            op = OP_READ;
        end
        else
        begin
            op = OP_NONE;
        end
    end

    // respond on the MEM_LATENCY-th cycle of a held request.
    assign resp = (op != OP_NONE) && (count == CNT_WIDTH'(MEM_LATENCY - 1));

    always_ff @(posedge clk)
    begin : latency_counter
        if (rst)
        begin
            count <= '0;
        end
        else if (op == OP_NONE || resp)
        begin
            count <= '0;
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    // ============================================================
    // storage
    // ============================================================

    always_ff @(posedge clk)
    begin : storage_write
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                lines[i] <= '0;
            end
        end
        else if (resp && op == OP_WRITE)
        begin
            lines[port.addr] <= port.wdata;
        end
    end

    // read data only in the response cycle.
    assign port.rdata = (resp && op == OP_READ) ? lines[port.addr] : '0;
    assign port.resp  = resp;

endmodule : main_memory

`default_nettype wire

// File: verilog/mem_arb_pkg.sv
`default_nettype none

package mem_arb_pkg;

    // ============================================================
    // arbiter grant states
    // ============================================================

    // idle grants nobody, the other two own the memory port.
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ICACHE,
        ARB_DCACHE
    } arb_state_t;

    // ============================================================
    // memory operations
    // ============================================================

    // decoded from the read and write strobes.
    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } mem_op_t;

endpackage : mem_arb_pkg

`default_nettype wire

// File: verilog/mem_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_port_if
#(
    parameter int ADDR_WIDTH = 6,
    parameter int LINE_WIDTH = 64
);

    // request side, held until resp.
    logic [ADDR_WIDTH-1:0] addr;
    logic                  read;
    logic                  write;
    logic [LINE_WIDTH-1:0] wdata;

    // response side, valid for one cycle.
    logic [LINE_WIDTH-1:0] rdata;
    logic                  resp;

    modport client
    (
        output addr,
        output read,
        output write,
        output wdata,
        input  rdata,
        input  resp
    );

    modport server
    (
        input  addr,
        input  read,
        input  write,
        input  wdata,
        output rdata,
        output resp
    );

endinterface : mem_port_if

`default_nettype wire

// File: verilog/mem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem
#(
    parameter int ADDR_WIDTH  = 6,
    parameter int LINE_WIDTH  = 64,
    parameter int MEM_LATENCY = 3
)
(
    input  logic                  clk,
    input  logic                  rst,

    // instruction cache, read only.
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic                  i_read,
    output logic [LINE_WIDTH-1:0] i_rdata,
    output logic                  i_resp,

    // data cache.
    input  logic [ADDR_WIDTH-1:0] d_addr,
    input  logic                  d_read,
    input  logic                  d_write,
    input  logic [LINE_WIDTH-1:0] d_wdata,
    output logic [LINE_WIDTH-1:0] d_rdata,
    output logic                  d_resp
);

    // ============================================================
    // port interfaces
    // ============================================================

    mem_port_if #(.ADDR_WIDTH(ADDR_WIDTH), .LINE_WIDTH(LINE_WIDTH)) icache_port ();
    mem_port_if #(.ADDR_WIDTH(ADDR_WIDTH), .LINE_WIDTH(LINE_WIDTH)) dcache_port ();
    mem_port_if #(.ADDR_WIDTH(ADDR_WIDTH), .LINE_WIDTH(LINE_WIDTH)) memory_port ();

    // instruction side.
    assign icache_port.addr  = i_addr;
    assign icache_port.read  = i_read;
    assign icache_port.write = 1'b0;
    assign icache_port.wdata = '0;
    assign i_rdata           = icache_port.rdata;
    assign i_resp            = icache_port.resp;

    // data side.
    assign dcache_port.addr  = d_addr;
    assign dcache_port.read  = d_read;
    assign dcache_port.write = d_write;
    assign dcache_port.wdata = d_wdata;
    assign d_rdata           = dcache_port.rdata;
    assign d_resp            = dcache_port.resp;

    // ============================================================
    // arbiter and memory
    // ============================================================

    cache_arbiter
    #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_WIDTH (LINE_WIDTH)
    )
    arbiter
    (
        .clk    (clk),
        .rst    (rst),
        .icache (icache_port.server),
        .dcache (dcache_port.server),
        .memory (memory_port.client)
    );

    main_memory
    #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .LINE_WIDTH  (LINE_WIDTH),
        .MEM_LATENCY (MEM_LATENCY)
    )
    memory
    (
        .clk  (clk),
        .rst  (rst),
        .port (memory_port.server)
    );

endmodule : mem_subsystem

`default_nettype wire
